//--- gcd_rgals_top.f
+incdir+hw
hw/gcd_pkg.sv
hw/rgals_tick_gen.sv
hw/rgals_suppressor.sv
hw/gcd_ctrl.sv
hw/gcd_dpath.sv
hw/gcd_rgals_top.sv
bench/gcd_rgals_tb.sv

//--- Makefile
# Verilator build for the GCD RGALS project

VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing -Wall
SIM_FLAGS   = --binary --timing --assert -j 0
TOP         = gcd_rgals_tb
RTL_TOP     = gcd_rgals_top
FILELIST    = gcd_rgals_top.f
BUILD_DIR   = obj_dir
LOG         = sim.log
PASS_TEXT   = No errors

SRCS = $(wildcard hw/*.sv hw/*.svh bench/*.sv)
BIN  = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/gcd_rgals_tb.sv
//------------------------------------------------
// self-checking testbench for gcd_rgals_top, random operands are 8 bits
// inputs change 2 ns after clk rises, outputs sampled at the rising edge
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "gcd_macros.svh"

module gcd_rgals_tb;

  localparam int CLK_PERIOD = 20;
  localparam int SEED       = 81722;
  localparam int NUM_RANDOM = 200;
  localparam int NUM_HELD   = 8;
  localparam int NUM_OPS    = 8 + NUM_RANDOM + NUM_HELD;
  // worst case subtract/swap steps plus two common window periods
  localparam int OP_CYCLES  = 2 * 255 * `GCD_CORE_DIV + 2 * `GCD_IO_DIV * `GCD_CORE_DIV;
  localparam int LIMIT_NS   = (NUM_OPS * OP_CYCLES + 10) * CLK_PERIOD;

  logic                  clk;
  logic                  clk_reset;
  logic                  req_val;
  logic                  req_rdy;
  logic [`GCD_WIDTH-1:0] req_a;
  logic [`GCD_WIDTH-1:0] req_b;
  logic                  resp_val;
  logic                  resp_rdy;
  logic [`GCD_WIDTH-1:0] resp_msg;

  // expected results, oldest first
  logic [`GCD_WIDTH-1:0] exp_q[$];
  logic [`GCD_WIDTH-1:0] expected;
  int                    resp_count = 0;

  gcd_rgals_top dut (
    .clk       (clk),
    .clk_reset (clk_reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .req_a     (req_a),
    .req_b     (req_b),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .resp_msg  (resp_msg)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // error reporting and reference model
  // --------------------------------------------------
  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at the first error");
  endtask

  // Euclid by remainder, gcd(x,0) = x
  function automatic logic [`GCD_WIDTH-1:0] ref_gcd(input logic [`GCD_WIDTH-1:0] x,
                                                    input logic [`GCD_WIDTH-1:0] y);
    logic [`GCD_WIDTH-1:0] a;
    logic [`GCD_WIDTH-1:0] b;
    logic [`GCD_WIDTH-1:0] t;
    a = x;
    b = y;
    while (b != '0) begin
      t = a % b;
      a = b;
      b = t;
    end
    return a;
  endfunction

  // --------------------------------------------------
  // comparing process
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!clk_reset) begin
      assert (!(req_rdy && resp_val))
        else report_mismatch("req_rdy and resp_val high in the same cycle");
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          report_failure("response transferred with no request outstanding");
        end
        expected = exp_q.pop_front();
        assert (resp_msg === expected)
          else report_mismatch($sformatf("resp_msg 0x%0h, expected 0x%0h",
                                         resp_msg, expected));
        resp_count <= resp_count + 1;
      end
      // queue the answer when the request crosses
      if (req_val && req_rdy) begin
        exp_q.push_back(ref_gcd(req_a, req_b));
      end
    end
  end

  // --------------------------------------------------
  // stimulus tasks, entered 2 ns after a rising edge
  // --------------------------------------------------
  task automatic send_request(input logic [`GCD_WIDTH-1:0] a, input logic [`GCD_WIDTH-1:0] b);
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    #2;
    req_val = 1'b0;
  endtask

  task automatic run_op(input logic [`GCD_WIDTH-1:0] a, input logic [`GCD_WIDTH-1:0] b);
    int target;
    target = resp_count + 1;
    send_request(a, b);
    while (resp_count < target) @(posedge clk);
    #2;
  endtask

  // hold resp_rdy low for some windows, result must not move
  task automatic run_held_op(input logic [`GCD_WIDTH-1:0] a, input logic [`GCD_WIDTH-1:0] b,
                             input int hold_windows);
    logic [`GCD_WIDTH-1:0] held;
    int                    pulses;
    int                    target;
    target   = resp_count + 1;
    pulses   = 0;
    held     = '0;
    resp_rdy = 1'b0;
    send_request(a, b);
    while (pulses < hold_windows) begin
      @(posedge clk);
      assert (!req_rdy) else report_mismatch("req_rdy high while a response is held");
      if (resp_val) begin
        if (pulses == 0) begin
          held = resp_msg;
        end else begin
          assert (resp_msg === held)
            else report_mismatch($sformatf("held resp_msg moved from 0x%0h to 0x%0h",
                                           held, resp_msg));
        end
        pulses++;
      end
    end
    #2;
    resp_rdy = 1'b1;
    while (resp_count < target) @(posedge clk);
    #2;
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    logic [`GCD_WIDTH-1:0] a;
    logic [`GCD_WIDTH-1:0] b;
    void'($urandom(SEED));
    clk       = 1'b0;
    clk_reset = 1'b1;
    req_val   = 1'b0;
    req_a     = '0;
    req_b     = '0;
    resp_rdy  = 1'b0;
    // strobes stay low through reset and the first cycle after
    repeat (3) begin
      @(posedge clk);
      assert (!req_rdy && !resp_val) else report_mismatch("strobe high during reset");
    end
    #2;
    clk_reset = 1'b0;
    resp_rdy  = 1'b1;
    @(posedge clk);
    assert (!req_rdy && !resp_val)
      else report_mismatch("strobe high in the first cycle after reset");
    #2;
    // directed pairs
    run_op(16'd15, 16'd10);
    run_op(16'd22, 16'd10);
    run_op(16'd36, 16'd18);
    run_op(16'd36, 16'd21);
    // zero and equal operands
    run_op(16'd0, 16'd0);
    run_op(16'd7, 16'd0);
    run_op(16'd0, 16'd9);
    run_op(16'd12, 16'd12);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a = `GCD_WIDTH'($urandom_range(255, 0));
      b = `GCD_WIDTH'($urandom_range(255, 0));
      run_op(a, b);
    end
    // back-pressure on the response side
    for (int i = 0; i < NUM_HELD; i++) begin
      a = `GCD_WIDTH'($urandom_range(255, 0));
      b = `GCD_WIDTH'($urandom_range(255, 0));
      run_held_op(a, b, $urandom_range(6, 1));
    end
    @(posedge clk);
    if (exp_q.size() != 0) begin
      report_failure("responses still missing at the end of the run");
    end else begin
      $display("No errors");
      $finish;
    end
  end

  // watchdog
  initial begin
    #(LIMIT_NS);
    report_failure($sformatf("timeout, the DUT made no progress within %0d ns", LIMIT_NS));
  end

endmodule

`default_nettype wire

//--- hw/gcd_rgals_top.sv
//------------------------------------------------
// GCD unit behind an io/core RGALS boundary, one clk for both domains
// req_a and req_b must hold until the request transfers
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "gcd_macros.svh"

module gcd_rgals_top (
  input  wire                   clk,
  input  wire                   clk_reset,
  input  wire                   req_val,
  output logic                  req_rdy,
  input  wire [`GCD_WIDTH-1:0]  req_a,
  input  wire [`GCD_WIDTH-1:0]  req_b,
  output logic                  resp_val,
  input  wire                   resp_rdy,
  output logic [`GCD_WIDTH-1:0] resp_msg
);

  import gcd_pkg::*;

  // domain enables
  logic   io_tick;
  logic   core_tick;

  // strobes on the core side of the boundary
  logic   core_req_val;
  logic   core_req_rdy;
  logic   core_resp_val;
  logic   core_resp_rdy;

  // control to datapath and back
  a_sel_e a_sel;
  b_sel_e b_sel;
  logic   a_en;
  logic   b_en;
  logic   is_a_lt_b;
  logic   is_b_zero;

  // -----------------------------------------------
  // clock-enable ticks, both in phase out of reset
  // -----------------------------------------------
  rgals_tick_gen #(.DIVIDE(`GCD_IO_DIV)) io_tick_gen (
    .clk       (clk),
    .clk_reset (clk_reset),
    .tick      (io_tick)
  );

  rgals_tick_gen #(.DIVIDE(`GCD_CORE_DIV)) core_tick_gen (
    .clk       (clk),
    .clk_reset (clk_reset),
    .tick      (core_tick)
  );

  // boundary strobe gating
  rgals_suppressor suppressor (
    .clk           (clk),
    .clk_reset     (clk_reset),
    .io_tick       (io_tick),
    .core_tick     (core_tick),
    .req_val_io    (req_val),
    .core_req_val  (core_req_val),
    .core_req_rdy  (core_req_rdy),
    .req_rdy_io    (req_rdy),
    .core_resp_val (core_resp_val),
    .resp_val_io   (resp_val),
    .resp_rdy_io   (resp_rdy),
    .core_resp_rdy (core_resp_rdy)
  );

  // -----------------------------------------------
  // core domain GCD unit
  // -----------------------------------------------
  gcd_ctrl ctrl (
    .clk       (clk),
    .clk_reset (clk_reset),
    .core_tick (core_tick),
    .req_val   (core_req_val),
    .req_rdy   (core_req_rdy),
    .resp_val  (core_resp_val),
    .resp_rdy  (core_resp_rdy),
    .is_a_lt_b (is_a_lt_b),
    .is_b_zero (is_b_zero),
    .a_sel     (a_sel),
    .a_en      (a_en),
    .b_sel     (b_sel),
    .b_en      (b_en)
  );

  gcd_dpath dpath (
    .clk       (clk),
    .req_a     (req_a),
    .req_b     (req_b),
    .a_sel     (a_sel),
    .a_en      (a_en),
    .b_sel     (b_sel),
    .b_en      (b_en),
    .is_a_lt_b (is_a_lt_b),
    .is_b_zero (is_b_zero),
    .result    (resp_msg)
  );

endmodule

`default_nettype wire

//--- hw/gcd_dpath.sv
//------------------------------------------------
// subtractive GCD datapath, registers have no reset
// result equals A only once B is zero
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "gcd_macros.svh"

module gcd_dpath (
  input  wire                   clk,
  input  wire [`GCD_WIDTH-1:0]  req_a,
  input  wire [`GCD_WIDTH-1:0]  req_b,
  input  wire gcd_pkg::a_sel_e  a_sel,
  input  wire                   a_en,
  input  wire gcd_pkg::b_sel_e  b_sel,
  input  wire                   b_en,
  output logic                  is_a_lt_b,
  output logic                  is_b_zero,
  output logic [`GCD_WIDTH-1:0] result
);

  import gcd_pkg::*;

  logic [`GCD_WIDTH-1:0] a_reg;
  logic [`GCD_WIDTH-1:0] b_reg;
  logic [`GCD_WIDTH-1:0] a_mux;
  logic [`GCD_WIDTH-1:0] b_mux;
  logic [`GCD_WIDTH-1:0] diff;

  // a - b, feeds A mux and the response
  assign diff = a_reg - b_reg;

  // input muxes
  always_comb begin
    case (a_sel)
      A_SEL_SUB: a_mux = diff;
      A_SEL_B:   a_mux = b_reg;
      default:   a_mux = req_a;
    endcase
  end

  assign b_mux = (b_sel == B_SEL_IN) ? req_b : a_reg;

  // operand registers
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux;
    end
    if (b_en) begin
      b_reg <= b_mux;
    end
  end

  // status back to control
  assign is_a_lt_b = (a_reg < b_reg);
  assign is_b_zero = (b_reg == '0);
  assign result    = diff;

  // the fourth select code is never driven while A loads
  a_sel_legal : assert property (
    @(posedge clk) a_en |-> (a_sel inside {A_SEL_IN, A_SEL_SUB, A_SEL_B})
  );

endmodule

`default_nettype wire

//--- hw/gcd_ctrl.sv
//------------------------------------------------
// IDLE/CALC/DONE control, state moves on core ticks only
// enables out are already qualified with core_tick
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gcd_ctrl (
  input  wire             clk,
  input  wire             clk_reset,
  input  wire             core_tick,
  input  wire             req_val,
  output logic            req_rdy,
  output logic            resp_val,
  input  wire             resp_rdy,
  input  wire             is_a_lt_b,
  input  wire             is_b_zero,
  output gcd_pkg::a_sel_e a_sel,
  output logic            a_en,
  output gcd_pkg::b_sel_e b_sel,
  output logic            b_en
);

  import gcd_pkg::*;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } state_e;

  state_e state;
  state_e state_next;
  logic   req_go;
  logic   resp_go;
  logic   calc_end;

  // transfers and the end of the loop, each on a core tick
  assign req_go   = core_tick && req_val && req_rdy;
  assign resp_go  = core_tick && resp_val && resp_rdy;
  assign calc_end = core_tick && !is_a_lt_b && is_b_zero;

  // -----------------------------------------------
  // state register and next state
  // -----------------------------------------------
  always_ff @(posedge clk or posedge clk_reset) begin
    if (clk_reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (req_go) state_next = CALC;
      CALC: if (calc_end) state_next = DONE;
      DONE: if (resp_go) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // -----------------------------------------------
  // outputs
  // -----------------------------------------------
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    a_sel    = A_SEL_IN;
    b_sel    = B_SEL_IN;
    a_en     = 1'b0;
    b_en     = 1'b0;
    case (state)
      IDLE: begin
        // latch both operands on the request transfer
        req_rdy = 1'b1;
        a_en    = req_go;
        b_en    = req_go;
      end
      CALC: begin
        // swap when a < b, else subtract, hold once b is zero
        a_sel = is_a_lt_b ? A_SEL_B : A_SEL_SUB;
        b_sel = B_SEL_A;
        a_en  = core_tick && !is_b_zero;
        b_en  = core_tick && is_a_lt_b;
      end
      DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  a_rdy_val_excl : assert property (
    @(posedge clk) disable iff (clk_reset) !(req_rdy && resp_val)
  );

endmodule

`default_nettype wire

//--- hw/rgals_suppressor.sv
//------------------------------------------------
// window only where io and core ticks meet at phase zero
// all gating is combinational, strobes only, data passes ungated
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "gcd_macros.svh"

module rgals_suppressor (
  input  wire  clk,
  input  wire  clk_reset,
  input  wire  io_tick,
  input  wire  core_tick,
  input  wire  req_val_io,
  output logic core_req_val,
  input  wire  core_req_rdy,
  output logic req_rdy_io,
  input  wire  core_resp_val,
  output logic resp_val_io,
  input  wire  resp_rdy_io,
  output logic core_resp_rdy
);

  logic [`GCD_PHASE_W-1:0] io_phase;
  logic [`GCD_PHASE_W-1:0] core_phase;
  logic                    window;

  // io ticks, modulo the core ratio
  always_ff @(posedge clk or posedge clk_reset) begin
    if (clk_reset) begin
      io_phase <= '0;
    end else if (io_tick) begin
      if (io_phase == `GCD_PHASE_W'(`GCD_CORE_DIV - 1)) begin
        io_phase <= '0;
      end else begin
        io_phase <= io_phase + 1'b1;
      end
    end
  end

  // core ticks, modulo the io ratio
  always_ff @(posedge clk or posedge clk_reset) begin
    if (clk_reset) begin
      core_phase <= '0;
    end else if (core_tick) begin
      if (core_phase == `GCD_PHASE_W'(`GCD_IO_DIV - 1)) begin
        core_phase <= '0;
      end else begin
        core_phase <= core_phase + 1'b1;
      end
    end
  end

  // -----------------------------------------------
  // transfer window and strobe gating
  // -----------------------------------------------

  // safe for both domains at once
  assign window = io_tick && core_tick && (io_phase == '0) && (core_phase == '0);

  // request io -> core, ready back
  assign core_req_val  = window && req_val_io;
  assign req_rdy_io    = window && core_req_rdy;
  // response core -> io, ready back
  assign resp_val_io   = window && core_resp_val;
  assign core_resp_rdy = window && resp_rdy_io;

  a_window_ticks : assert property (
    @(posedge clk) disable iff (clk_reset) window |-> (io_tick && core_tick)
  );

endmodule

`default_nettype wire

//--- hw/rgals_tick_gen.sv
//------------------------------------------------
// one-cycle clock-enable every DIVIDE clk cycles, DIVIDE >= 2
// first tick in the second cycle after clk_reset falls
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "gcd_macros.svh"

module rgals_tick_gen #(
  parameter int DIVIDE = 3
) (
  input  wire  clk,
  input  wire  clk_reset,
  output logic tick
);

  logic [`GCD_PHASE_W-1:0] count;

  // wrapping phase counter
  always_ff @(posedge clk or posedge clk_reset) begin
    if (clk_reset) begin
      count <= '0;
    end else if (count == `GCD_PHASE_W'(DIVIDE - 1)) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // phase one, so every generator fires on the first edge out of reset
  assign tick = (count == `GCD_PHASE_W'(1));

  // a tick is a single-cycle pulse
  a_tick_single : assert property (
    @(posedge clk) disable iff (clk_reset) ((DIVIDE > 1) && tick) |=> !tick
  );

endmodule

`default_nettype wire

//--- hw/gcd_pkg.sv
//------------------------------------------------
// mux selects shared by the GCD control and datapath
//------------------------------------------------
`default_nettype none

package gcd_pkg;

  // A register input
  typedef enum logic [1:0] {
    A_SEL_IN  = 2'd0,
    A_SEL_SUB = 2'd1,
    A_SEL_B   = 2'd2
  } a_sel_e;

  // B register input
  typedef enum logic {
    B_SEL_A  = 1'b0,
    B_SEL_IN = 1'b1
  } b_sel_e;

endpackage

`default_nettype wire

//--- hw/gcd_macros.svh
//------------------------------------------------
// GCD_IO_DIV and GCD_CORE_DIV must be coprime, so both ticks line up
// once every GCD_IO_DIV * GCD_CORE_DIV cycles of clk
// GCD_PHASE_W must hold the larger of the two ratios
//------------------------------------------------
`ifndef GCD_MACROS_SVH
`define GCD_MACROS_SVH

// operand and result width
`define GCD_WIDTH 16

// clk cycles per io tick and per core tick
`define GCD_IO_DIV   5
`define GCD_CORE_DIV 3

// tick and phase counter width
`define GCD_PHASE_W 3

`endif
